// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// Unit id tag carried by every command and echoed back by the memory side
	localparam int cu_id_bits = 2;

	typedef logic [cu_id_bits-1:0] cu_id_t;

	typedef enum logic {
		cmd_read,
		cmd_write
	} cmd_opcode;

	// Fields echoed on data and response lines
	typedef struct packed {
		cu_id_t      cu_id;
		logic [31:0] address;
		logic [15:0] tag;
	} cmd_fields;

	typedef struct packed {
		logic      valid;
		cmd_opcode opcode;
		cmd_fields cmd;
	} command_line;

	typedef struct packed {
		logic        valid;
		cmd_fields   cmd;
		logic [31:0] data;
	} data_line;

	typedef struct packed {
		logic      valid;
		cmd_fields cmd;
		cmd_opcode opcode;
	} response_line;

	typedef struct packed {
		logic valid;
		logic empty;
		logic alfull;
		logic full;
	} buffer_status;

endpackage

`default_nettype wire

// File: common/graph_pkg.sv
`default_nettype none

package graph_pkg;

	localparam int num_vertex_cu        = 4;
	localparam int vertex_bits          = 16;
	localparam int vertex_buffer_depth  = 16;
	localparam int command_buffer_depth = 8;

	// Work element from the host
	typedef struct packed {
		logic                   valid;
		logic [vertex_bits-1:0] num_vertices;
		logic [31:0]            result_base;
	} wed_line;

	typedef struct packed {
		logic                   valid;
		logic [vertex_bits-1:0] vertex_id;
		logic [31:0]            neighbour_address;
		logic [3:0]             shift;
	} vertex_job;

	typedef enum logic [2:0] {
		cu_idle,
		cu_read,
		cu_wait_data,
		cu_write,
		cu_wait_response
	} cu_state;

endpackage

`default_nettype wire

// File: logic/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
	parameter int width = 32,
	parameter int depth = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [width-1:0] data_in,
	input  logic             pop,
	output logic [width-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty,
	output logic             valid
);

	logic [width-1:0] mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth):0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			valid <= do_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// Head entry is visible before the pop
	assign data_out = mem[rd_ptr];
	assign empty    = (count == 0);
	assign full     = (count == depth);
	assign alfull   = (count >= depth - 4);

endmodule

`default_nettype wire

// File: logic/rr_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
	parameter int num_requests = 4,
	parameter int width        = 32
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  logic [width-1:0]        buffer_in [num_requests],
	input  logic [num_requests-1:0] requests,
	output logic [width-1:0]        arbiter_out,
	output logic [num_requests-1:0] ready
);

	logic [$clog2(num_requests)-1:0] last_winner;
	logic [$clog2(num_requests)-1:0] winner;
	logic found;

	// Search starts one past the previous winner
	always_comb begin
		int idx;
		ready  = '0;
		winner = last_winner;
		found  = 1'b0;
		for (int k = 1; k <= num_requests; k++) begin
			idx = (int'(last_winner) + k) % num_requests;
			if (!found && enabled && requests[idx]) begin
				found      = 1'b1;
				winner     = idx[$clog2(num_requests)-1:0];
				ready[idx] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_winner <= '0;
			arbiter_out <= '0;
		end else if (found) begin
			last_winner <= winner;
			arbiter_out <= buffer_in[winner];
		end else begin
			arbiter_out <= '0;
		end
	end

endmodule

`default_nettype wire

// File: vertex_cu/vertex_cu.sv
`timescale 1ns/10ps
`default_nettype none

module vertex_cu #(
	parameter int cu_id = 0
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enabled,
	input  graph_pkg::wed_line                  wed_request,
	input  graph_pkg::vertex_job                vertex_job,
	output logic                                job_request,
	input  mem_pkg::data_line                   read_data,
	input  mem_pkg::response_line               read_response,
	output mem_pkg::command_line                read_command,
	input  mem_pkg::buffer_status               read_buffer_status,
	output mem_pkg::command_line                write_command,
	output mem_pkg::data_line                   write_data,
	input  mem_pkg::buffer_status               write_buffer_status,
	input  mem_pkg::response_line               write_response,
	output logic [graph_pkg::vertex_bits-1:0]   finished_count
);

	graph_pkg::cu_state state;
	graph_pkg::vertex_job job_q;
	logic [31:0] data_q;
	logic got_data;
	logic got_resp;
	mem_pkg::cmd_fields write_fields;

	assign job_request = enabled && wed_request.valid && (state == graph_pkg::cu_idle);

	// Contribution goes to result_base plus the vertex id
	assign write_fields.cu_id   = mem_pkg::cu_id_t'(cu_id);
	assign write_fields.address = wed_request.result_base + 32'(job_q.vertex_id);
	assign write_fields.tag     = job_q.vertex_id;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= graph_pkg::cu_idle;
			got_data       <= 1'b0;
			got_resp       <= 1'b0;
			finished_count <= '0;
			read_command   <= '0;
			write_command  <= '0;
			write_data     <= '0;
		end else begin
			read_command.valid  <= 1'b0;
			write_command.valid <= 1'b0;
			write_data.valid    <= 1'b0;
			case (state)
				graph_pkg::cu_idle: begin
					if (vertex_job.valid)
						state <= graph_pkg::cu_read;
				end
				graph_pkg::cu_read: begin
					if (enabled && !read_buffer_status.alfull) begin
						read_command.valid     <= 1'b1;
						read_command.opcode    <= mem_pkg::cmd_read;
						read_command.cmd.cu_id <= mem_pkg::cu_id_t'(cu_id);
						read_command.cmd.address <= job_q.neighbour_address;
						read_command.cmd.tag   <= job_q.vertex_id;
						got_data <= 1'b0;
						got_resp <= 1'b0;
						state    <= graph_pkg::cu_wait_data;
					end
				end
				graph_pkg::cu_wait_data: begin
					// Data and response may come back in either order
					if (read_data.valid)
						got_data <= 1'b1;
					if (read_response.valid)
						got_resp <= 1'b1;
					if ((got_data || read_data.valid) && (got_resp || read_response.valid))
						state <= graph_pkg::cu_write;
				end
				graph_pkg::cu_write: begin
					if (enabled && !write_buffer_status.alfull) begin
						write_command.valid  <= 1'b1;
						write_command.opcode <= mem_pkg::cmd_write;
						write_command.cmd    <= write_fields;
						write_data.valid     <= 1'b1;
						write_data.cmd       <= write_fields;
						write_data.data      <= data_q >> job_q.shift;
						state <= graph_pkg::cu_wait_response;
					end
				end
				graph_pkg::cu_wait_response: begin
					if (write_response.valid) begin
						finished_count <= finished_count + 1'b1;
						state          <= graph_pkg::cu_idle;
					end
				end
				default: state <= graph_pkg::cu_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == graph_pkg::cu_idle && vertex_job.valid)
			job_q <= vertex_job;
		if (state == graph_pkg::cu_wait_data && read_data.valid)
			data_q <= read_data.data;
	end

endmodule

`default_nettype wire

// File: graph_control/graph_control.sv
`timescale 1ns/10ps
`default_nettype none

module graph_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  graph_pkg::wed_line    wed_request,
	input  mem_pkg::data_line     read_data,
	input  mem_pkg::response_line read_response,
	input  mem_pkg::response_line write_response,
	input  mem_pkg::buffer_status read_buffer_status,
	input  mem_pkg::buffer_status write_buffer_status,
	input  graph_pkg::vertex_job  vertex_job,
	output mem_pkg::command_line  read_command,
	output mem_pkg::command_line  write_command,
	output mem_pkg::data_line     write_data,
	output logic                  vertex_job_request,
	output logic                  done_graph_algorithm
);

	// Write command and its data share one FIFO entry
	typedef struct packed {
		mem_pkg::command_line cmd;
		mem_pkg::data_line    data;
	} write_entry;

	graph_pkg::wed_line    wed_q;
	mem_pkg::data_line     read_data_q;
	mem_pkg::response_line read_response_q;
	mem_pkg::response_line write_response_q;
	graph_pkg::vertex_job  vertex_job_q;
	logic enabled_q;

	mem_pkg::data_line     read_data_cu      [graph_pkg::num_vertex_cu];
	mem_pkg::response_line read_response_cu  [graph_pkg::num_vertex_cu];
	mem_pkg::response_line write_response_cu [graph_pkg::num_vertex_cu];

	mem_pkg::buffer_status vertex_status;
	logic [$bits(graph_pkg::vertex_job)-1:0] job_fifo_out;
	logic [$bits(graph_pkg::vertex_job)-1:0] job_arb_in [graph_pkg::num_vertex_cu];
	graph_pkg::vertex_job job_line;
	graph_pkg::vertex_job vertex_job_cu [graph_pkg::num_vertex_cu];
	logic [graph_pkg::num_vertex_cu-1:0] job_req_cu;
	logic [graph_pkg::num_vertex_cu-1:0] job_arb_req;
	logic [graph_pkg::num_vertex_cu-1:0] job_ready;
	logic [graph_pkg::num_vertex_cu-1:0] job_grant_q;

	mem_pkg::command_line  read_command_cu  [graph_pkg::num_vertex_cu];
	mem_pkg::command_line  write_command_cu [graph_pkg::num_vertex_cu];
	mem_pkg::data_line     write_data_cu    [graph_pkg::num_vertex_cu];
	mem_pkg::buffer_status read_status_cu   [graph_pkg::num_vertex_cu];
	mem_pkg::buffer_status write_status_cu  [graph_pkg::num_vertex_cu];
	logic [$bits(mem_pkg::command_line)-1:0] read_fifo_out [graph_pkg::num_vertex_cu];
	logic [$bits(write_entry)-1:0] write_fifo_out [graph_pkg::num_vertex_cu];
	logic [graph_pkg::num_vertex_cu-1:0] read_req;
	logic [graph_pkg::num_vertex_cu-1:0] read_ready;
	logic [graph_pkg::num_vertex_cu-1:0] write_req;
	logic [graph_pkg::num_vertex_cu-1:0] write_ready;
	mem_pkg::command_line read_arb_out;
	write_entry write_arb_out;

	logic [graph_pkg::vertex_bits-1:0] finished_count_cu [graph_pkg::num_vertex_cu];
	logic [graph_pkg::vertex_bits-1:0] finished_sum;
	logic done_next;

	////////////////////////////////////////
	// Input latch
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_q            <= '0;
			read_data_q      <= '0;
			read_response_q  <= '0;
			write_response_q <= '0;
			vertex_job_q     <= '0;
			enabled_q        <= 1'b0;
		end else begin
			enabled_q <= enabled;
			if (enabled) begin
				wed_q            <= wed_request;
				read_data_q      <= read_data;
				read_response_q  <= read_response;
				write_response_q <= write_response;
				vertex_job_q     <= vertex_job;
			end
		end
	end

	////////////////////////////////////////
	// Route by unit id
	////////////////////////////////////////

	// Only lines captured on the last edge are forwarded, so a held line is not repeated
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < graph_pkg::num_vertex_cu; i++) begin
				read_data_cu[i]      <= '0;
				read_response_cu[i]  <= '0;
				write_response_cu[i] <= '0;
			end
		end else begin
			for (int i = 0; i < graph_pkg::num_vertex_cu; i++) begin
				read_data_cu[i]      <= '0;
				read_response_cu[i]  <= '0;
				write_response_cu[i] <= '0;
				if (enabled_q && read_data_q.valid &&
					read_data_q.cmd.cu_id == mem_pkg::cu_id_t'(i))
					read_data_cu[i] <= read_data_q;
				if (enabled_q && read_response_q.valid &&
					read_response_q.cmd.cu_id == mem_pkg::cu_id_t'(i))
					read_response_cu[i] <= read_response_q;
				if (enabled_q && write_response_q.valid &&
					write_response_q.cmd.cu_id == mem_pkg::cu_id_t'(i))
					write_response_cu[i] <= write_response_q;
			end
		end
	end

	////////////////////////////////////////
	// Vertex job buffer and dispatch
	////////////////////////////////////////

	sync_fifo #(
		.width($bits(graph_pkg::vertex_job)),
		.depth(graph_pkg::vertex_buffer_depth)
	) vertex_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_job_q.valid && enabled_q),
		.data_in (vertex_job_q),
		.pop     (|job_ready),
		.data_out(job_fifo_out),
		.full    (vertex_status.full),
		.alfull  (vertex_status.alfull),
		.empty   (vertex_status.empty),
		.valid   (vertex_status.valid)
	);

	rr_arbiter #(
		.num_requests(graph_pkg::num_vertex_cu),
		.width       ($bits(graph_pkg::vertex_job))
	) job_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.buffer_in  (job_arb_in),
		.requests   (job_arb_req),
		.arbiter_out(job_line),
		.ready      (job_ready)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			job_grant_q <= '0;
		else
			job_grant_q <= job_ready;
	end

	// Registered job goes only to the unit granted on the last edge
	always_comb begin
		for (int i = 0; i < graph_pkg::num_vertex_cu; i++) begin
			vertex_job_cu[i]       = job_line;
			vertex_job_cu[i].valid = job_line.valid && job_grant_q[i];
		end
	end

	////////////////////////////////////////
	// Compute units and command buffers
	////////////////////////////////////////

	for (genvar i = 0; i < graph_pkg::num_vertex_cu; i++) begin : gen_unit
		assign job_arb_in[i]  = job_fifo_out;
		// A unit served last cycle sees its job now, so mask its request
		assign job_arb_req[i] = job_req_cu[i] && !job_grant_q[i] && !vertex_status.empty;
		assign read_req[i]    = !read_status_cu[i].empty && !read_buffer_status.alfull;
		assign write_req[i]   = !write_status_cu[i].empty && !write_buffer_status.alfull;

		vertex_cu #(
			.cu_id(i)
		) unit (
			.clock              (clock),
			.rstn               (rstn),
			.enabled            (enabled),
			.wed_request        (wed_q),
			.vertex_job         (vertex_job_cu[i]),
			.job_request        (job_req_cu[i]),
			.read_data          (read_data_cu[i]),
			.read_response      (read_response_cu[i]),
			.read_command       (read_command_cu[i]),
			.read_buffer_status (read_status_cu[i]),
			.write_command      (write_command_cu[i]),
			.write_data         (write_data_cu[i]),
			.write_buffer_status(write_status_cu[i]),
			.write_response     (write_response_cu[i]),
			.finished_count     (finished_count_cu[i])
		);

		sync_fifo #(
			.width($bits(mem_pkg::command_line)),
			.depth(graph_pkg::command_buffer_depth)
		) read_fifo (
			.clock   (clock),
			.rstn    (rstn),
			.push    (read_command_cu[i].valid),
			.data_in (read_command_cu[i]),
			.pop     (read_ready[i]),
			.data_out(read_fifo_out[i]),
			.full    (read_status_cu[i].full),
			.alfull  (read_status_cu[i].alfull),
			.empty   (read_status_cu[i].empty),
			.valid   (read_status_cu[i].valid)
		);

		sync_fifo #(
			.width($bits(write_entry)),
			.depth(graph_pkg::command_buffer_depth)
		) write_fifo (
			.clock   (clock),
			.rstn    (rstn),
			.push    (write_command_cu[i].valid),
			.data_in ({write_command_cu[i], write_data_cu[i]}),
			.pop     (write_ready[i]),
			.data_out(write_fifo_out[i]),
			.full    (write_status_cu[i].full),
			.alfull  (write_status_cu[i].alfull),
			.empty   (write_status_cu[i].empty),
			.valid   (write_status_cu[i].valid)
		);
	end

	////////////////////////////////////////
	// Port arbitration and output register
	////////////////////////////////////////

	rr_arbiter #(
		.num_requests(graph_pkg::num_vertex_cu),
		.width       ($bits(mem_pkg::command_line))
	) read_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.buffer_in  (read_fifo_out),
		.requests   (read_req),
		.arbiter_out(read_arb_out),
		.ready      (read_ready)
	);

	rr_arbiter #(
		.num_requests(graph_pkg::num_vertex_cu),
		.width       ($bits(write_entry))
	) write_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.buffer_in  (write_fifo_out),
		.requests   (write_req),
		.arbiter_out(write_arb_out),
		.ready      (write_ready)
	);

	always_comb begin
		finished_sum = '0;
		for (int i = 0; i < graph_pkg::num_vertex_cu; i++)
			finished_sum = finished_sum + finished_count_cu[i];
	end

	// Done is sticky once every vertex has its write response
	assign done_next = done_graph_algorithm ||
		(wed_q.valid && finished_sum >= wed_q.num_vertices);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command         <= '0;
			write_command        <= '0;
			write_data           <= '0;
			vertex_job_request   <= 1'b0;
			done_graph_algorithm <= 1'b0;
		end else begin
			read_command         <= read_arb_out;
			write_command        <= write_arb_out.cmd;
			write_data           <= write_arb_out.data;
			vertex_job_request   <= enabled && !done_next && !vertex_status.alfull;
			done_graph_algorithm <= done_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/graph_top.sv
`timescale 1ns/10ps
`default_nettype none

module graph_top (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  graph_pkg::wed_line    wed_request,
	input  mem_pkg::data_line     read_data,
	input  mem_pkg::response_line read_response,
	input  mem_pkg::response_line write_response,
	input  mem_pkg::buffer_status read_buffer_status,
	input  mem_pkg::buffer_status write_buffer_status,
	input  graph_pkg::vertex_job  vertex_job,
	output mem_pkg::command_line  read_command,
	output mem_pkg::command_line  write_command,
	output mem_pkg::data_line     write_data,
	output logic                  vertex_job_request,
	output logic                  done_graph_algorithm
);

	graph_control control (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (enabled),
		.wed_request         (wed_request),
		.read_data           (read_data),
		.read_response       (read_response),
		.write_response      (write_response),
		.read_buffer_status  (read_buffer_status),
		.write_buffer_status (write_buffer_status),
		.vertex_job          (vertex_job),
		.read_command        (read_command),
		.write_command       (write_command),
		.write_data          (write_data),
		.vertex_job_request  (vertex_job_request),
		.done_graph_algorithm(done_graph_algorithm)
	);

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int period       = 100,
	parameter int reset_cycles = 8
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// Release 5 ns after a rising edge
	initial begin
		rstn = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		#5;
		rstn = 1'b1;
	end

endmodule

`default_nettype wire

// File: test/tb_mem_responder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_responder #(
	parameter int num_jobs = 40
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   pause,
	input  logic [31:0]            mem_image [256],
	input  graph_pkg::vertex_job   job_list [num_jobs],
	input  mem_pkg::command_line   read_command,
	input  mem_pkg::command_line   write_command,
	input  logic                   vertex_job_request,
	output mem_pkg::data_line      read_data,
	output mem_pkg::response_line  read_response,
	output mem_pkg::response_line  write_response,
	output mem_pkg::buffer_status  read_buffer_status,
	output mem_pkg::buffer_status  write_buffer_status,
	output graph_pkg::vertex_job   vertex_job,
	output int                     write_responses_given
);

	mem_pkg::command_line read_queue [$];
	int read_due [$];
	mem_pkg::command_line write_queue [$];
	int write_due [$];
	int cycle;
	int next_job;
	logic pause_s;
	logic request_s;

	initial begin
		read_data             = '0;
		read_response         = '0;
		write_response        = '0;
		read_buffer_status    = '0;
		write_buffer_status   = '0;
		vertex_job            = '0;
		write_responses_given = 0;
		cycle     = 0;
		next_job  = 0;
		pause_s   = 1'b0;
		request_s = 1'b0;
	end

	// Capture DUT outputs mid-cycle
	always @(negedge clock) begin
		pause_s   = pause;
		request_s = vertex_job_request && rstn;
		if (rstn && read_command.valid) begin
			read_queue.push_back(read_command);
			read_due.push_back(cycle + 1 + int'($urandom_range(5)));
		end
		if (rstn && write_command.valid) begin
			write_queue.push_back(write_command);
			write_due.push_back(cycle + 1 + int'($urandom_range(3)));
		end
	end

	initial begin
		int idx;
		mem_pkg::command_line c;
		forever begin
			@(posedge clock);
			#5;
			cycle++;
			read_data      = '0;
			read_response  = '0;
			write_response = '0;
			vertex_job     = '0;
			read_buffer_status.alfull  = ($urandom_range(3) == 0);
			write_buffer_status.alfull = ($urandom_range(3) == 0);
			if (rstn && !pause_s) begin
				// Oldest due read goes first so units can overtake each other
				idx = -1;
				for (int i = 0; i < read_due.size(); i++)
					if (idx < 0 && read_due[i] <= cycle)
						idx = i;
				if (idx >= 0) begin
					c = read_queue[idx];
					read_queue.delete(idx);
					read_due.delete(idx);
					read_data.valid       = 1'b1;
					read_data.cmd         = c.cmd;
					read_data.data        = mem_image[c.cmd.address[7:0]];
					read_response.valid   = 1'b1;
					read_response.cmd     = c.cmd;
					read_response.opcode  = mem_pkg::cmd_read;
				end
				idx = -1;
				for (int i = 0; i < write_due.size(); i++)
					if (idx < 0 && write_due[i] <= cycle)
						idx = i;
				if (idx >= 0) begin
					c = write_queue[idx];
					write_queue.delete(idx);
					write_due.delete(idx);
					write_response.valid  = 1'b1;
					write_response.cmd    = c.cmd;
					write_response.opcode = mem_pkg::cmd_write;
					write_responses_given++;
				end
				// Job source skips some requested cycles
				if (request_s && next_job < num_jobs && $urandom_range(3) != 0) begin
					vertex_job = job_list[next_job];
					next_job++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: test/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top;

	localparam int num_jobs   = 40;
	localparam int wait_limit = 20000;
	localparam int num_tests  = 5;

	logic clock;
	logic rstn;
	logic enabled;
	logic pause;
	graph_pkg::wed_line    wed_request;
	mem_pkg::data_line     read_data;
	mem_pkg::response_line read_response;
	mem_pkg::response_line write_response;
	mem_pkg::buffer_status read_buffer_status;
	mem_pkg::buffer_status write_buffer_status;
	graph_pkg::vertex_job  vertex_job;
	mem_pkg::command_line  read_command;
	mem_pkg::command_line  write_command;
	mem_pkg::data_line     write_data;
	logic vertex_job_request;
	logic done_graph_algorithm;
	int write_responses_given;

	logic [31:0] mem_image [256];
	graph_pkg::vertex_job job_list [num_jobs];
	mem_pkg::cu_id_t read_owner [num_jobs];
	bit read_seen [num_jobs];
	bit write_seen [num_jobs];
	int error_count [num_tests];
	string test_name [num_tests];
	int check_count;
	int reads_total;
	int writes_total;
	logic read_alfull_d1, read_alfull_d2;
	logic write_alfull_d1, write_alfull_d2;
	logic enabled_d1, enabled_d2;
	bit done_seen;

	tb_clock clocks (
		.clock(clock),
		.rstn (rstn)
	);

	tb_mem_responder #(
		.num_jobs(num_jobs)
	) responder (
		.clock                (clock),
		.rstn                 (rstn),
		.pause                (pause),
		.mem_image            (mem_image),
		.job_list             (job_list),
		.read_command         (read_command),
		.write_command        (write_command),
		.vertex_job_request   (vertex_job_request),
		.read_data            (read_data),
		.read_response        (read_response),
		.write_response       (write_response),
		.read_buffer_status   (read_buffer_status),
		.write_buffer_status  (write_buffer_status),
		.vertex_job           (vertex_job),
		.write_responses_given(write_responses_given)
	);

	graph_top dut0 (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (enabled),
		.wed_request         (wed_request),
		.read_data           (read_data),
		.read_response       (read_response),
		.write_response      (write_response),
		.read_buffer_status  (read_buffer_status),
		.write_buffer_status (write_buffer_status),
		.vertex_job          (vertex_job),
		.read_command        (read_command),
		.write_command       (write_command),
		.write_data          (write_data),
		.vertex_job_request  (vertex_job_request),
		.done_graph_algorithm(done_graph_algorithm)
	);

	////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////

	task automatic report_error(input int test, input string what);
		$display("ERROR at %0t: %s", $time, what);
		error_count[test]++;
	endtask

	task automatic compare_command(input int test, input string name,
		input mem_pkg::command_line got, input mem_pkg::command_line exp);
		check_count++;
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
			error_count[test]++;
		end
	endtask

	task automatic compare_data(input int test, input string name,
		input mem_pkg::data_line got, input mem_pkg::data_line exp);
		check_count++;
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
			error_count[test]++;
		end
	endtask

	task automatic compare_flag(input int test, input string name, input logic got,
		input logic exp);
		check_count++;
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
			error_count[test]++;
		end
	endtask

	function automatic int find_job(input logic [15:0] vertex_id);
		int idx;
		idx = -1;
		for (int i = 0; i < num_jobs; i++)
			if (job_list[i].vertex_id == vertex_id)
				idx = i;
		return idx;
	endfunction

	task automatic wait_reset(output bit ok);
		int cycles;
		cycles = 0;
		while (!rstn && cycles < wait_limit) begin
			@(posedge clock);
			cycles++;
		end
		ok = rstn;
		if (!ok)
			$display("Timeout: reset was never released");
	endtask

	task automatic wait_done(output bit ok);
		int cycles;
		cycles = 0;
		while (!done_graph_algorithm && cycles < wait_limit) begin
			@(posedge clock);
			cycles++;
		end
		ok = done_graph_algorithm;
		if (!ok)
			$display("Timeout: done_graph_algorithm never rose");
	endtask

	////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////

	always @(negedge clock) begin
		int idx;
		mem_pkg::command_line exp_cmd;
		mem_pkg::data_line exp_data;
		if (rstn && read_command.valid) begin
			reads_total++;
			idx = find_job(read_command.cmd.tag);
			if (idx < 0) begin
				report_error(0, "read command carries an unknown vertex id");
			end else begin
				if (read_seen[idx])
					report_error(0, "vertex was read more than once");
				read_seen[idx]  = 1'b1;
				read_owner[idx] = read_command.cmd.cu_id;
				exp_cmd             = '0;
				exp_cmd.valid       = 1'b1;
				exp_cmd.opcode      = mem_pkg::cmd_read;
				exp_cmd.cmd.cu_id   = read_command.cmd.cu_id;
				exp_cmd.cmd.address = job_list[idx].neighbour_address;
				exp_cmd.cmd.tag     = job_list[idx].vertex_id;
				compare_command(0, "read_command", read_command, exp_cmd);
			end
			// Commands two cycles after a stall are past the pipeline margin
			if (read_alfull_d2)
				report_error(2, "read command issued after the read port was almost full");
			if (!enabled_d2)
				report_error(4, "read command issued while the DUT was disabled");
		end
		if (rstn && (write_command.valid || write_data.valid)) begin
			writes_total++;
			idx = find_job(write_command.cmd.tag);
			if (idx < 0) begin
				report_error(1, "write command carries an unknown vertex id");
			end else begin
				if (write_seen[idx])
					report_error(1, "vertex was written more than once");
				if (!read_seen[idx])
					report_error(1, "vertex was written before it was read");
				write_seen[idx]     = 1'b1;
				exp_cmd             = '0;
				exp_cmd.valid       = 1'b1;
				exp_cmd.opcode      = mem_pkg::cmd_write;
				exp_cmd.cmd.cu_id   = read_owner[idx];
				exp_cmd.cmd.address = wed_request.result_base + 32'(job_list[idx].vertex_id);
				exp_cmd.cmd.tag     = job_list[idx].vertex_id;
				compare_command(1, "write_command", write_command, exp_cmd);
				exp_data       = '0;
				exp_data.valid = 1'b1;
				exp_data.cmd   = exp_cmd.cmd;
				exp_data.data  = mem_image[job_list[idx].neighbour_address[7:0]] >>
					job_list[idx].shift;
				compare_data(1, "write_data", write_data, exp_data);
			end
			if (write_alfull_d2)
				report_error(2, "write command issued after the write port was almost full");
			if (!enabled_d2)
				report_error(4, "write command issued while the DUT was disabled");
		end
		if (rstn) begin
			if (done_graph_algorithm && write_responses_given < num_jobs)
				report_error(3, "done rose before all write responses were given");
			if (done_seen) begin
				compare_flag(3, "done_graph_algorithm", done_graph_algorithm, 1'b1);
				compare_flag(3, "vertex_job_request", vertex_job_request, 1'b0);
			end
			if (done_graph_algorithm)
				done_seen = 1'b1;
		end
		read_alfull_d2  = read_alfull_d1;
		read_alfull_d1  = read_buffer_status.alfull;
		write_alfull_d2 = write_alfull_d1;
		write_alfull_d1 = write_buffer_status.alfull;
		enabled_d2      = enabled_d1;
		enabled_d1      = enabled;
	end

	////////////////////////////////////////
	// Stimulus and result
	////////////////////////////////////////

	initial begin
		bit ok;
		int passed;
		int total_errors;
		void'($urandom(32'h15346bb7));
		enabled     = 1'b1;
		pause       = 1'b0;
		wed_request = '0;
		check_count  = 0;
		reads_total  = 0;
		writes_total = 0;
		done_seen    = 1'b0;
		read_alfull_d1  = 1'b0;
		read_alfull_d2  = 1'b0;
		write_alfull_d1 = 1'b0;
		write_alfull_d2 = 1'b0;
		enabled_d1 = 1'b1;
		enabled_d2 = 1'b1;
		test_name = '{"read commands", "write commands", "port back-pressure",
			"done detection", "enable hold"};
		for (int i = 0; i < num_tests; i++)
			error_count[i] = 0;
		for (int a = 0; a < 256; a++)
			mem_image[a] = $urandom();
		// Spaced ranges keep vertex ids distinct
		for (int i = 0; i < num_jobs; i++) begin
			job_list[i]                   = '0;
			job_list[i].valid             = 1'b1;
			job_list[i].vertex_id         = 16'(i * 1601 + int'($urandom_range(1600)));
			job_list[i].neighbour_address = 32'($urandom_range(255));
			job_list[i].shift             = 4'($urandom_range(15));
			read_seen[i]  = 1'b0;
			write_seen[i] = 1'b0;
			read_owner[i] = '0;
		end
		wed_request.valid        = 1'b1;
		wed_request.num_vertices = 16'(num_jobs);
		wed_request.result_base  = $urandom();

		wait_reset(ok);
		if (ok) begin
			repeat (10 + $urandom_range(30)) @(posedge clock);
			// Memory side goes quiet one cycle before enabled drops
			#5;
			pause = 1'b1;
			@(posedge clock);
			#5;
			enabled = 1'b0;
			repeat (20 + $urandom_range(40)) @(posedge clock);
			#5;
			enabled = 1'b1;
			@(posedge clock);
			#5;
			pause = 1'b0;
			wait_done(ok);
		end
		if (ok)
			repeat (30) @(posedge clock);

		for (int i = 0; i < num_jobs; i++) begin
			compare_flag(0, "vertex read", read_seen[i], 1'b1);
			compare_flag(1, "vertex written", write_seen[i], 1'b1);
		end
		compare_flag(2, "read count complete", reads_total == num_jobs, 1'b1);
		compare_flag(2, "write count complete", writes_total == num_jobs, 1'b1);
		compare_flag(3, "all write responses given", write_responses_given == num_jobs, 1'b1);
		compare_flag(4, "run completed after hold", done_graph_algorithm, 1'b1);

		passed       = 0;
		total_errors = 0;
		for (int i = 0; i < num_tests; i++) begin
			$display("test %0d %s: %s, %0d errors", i + 1, test_name[i],
				error_count[i] == 0 ? "ok" : "failed", error_count[i]);
			if (error_count[i] == 0)
				passed++;
			total_errors += error_count[i];
		end
		$display("tests %0d passed, %0d failed, %0d checks, %0d errors", passed,
			num_tests - passed, check_count, total_errors);
		if (ok && total_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
common/mem_pkg.sv
common/graph_pkg.sv
logic/sync_fifo.sv
logic/rr_arbiter.sv
vertex_cu/vertex_cu.sv
graph_control/graph_control.sv
logic/graph_top.sv
test/tb_clock.sv
test/tb_mem_responder.sv
test/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the graph control testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
